/* src/fb_defs.svh */
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// ========================================
// Data and SDRAM geometry
// ========================================
`define FB_DATA_W           16    // Pixel and DQ width
`define FB_BANK_W           2
`define FB_ROW_W            13    // Also the SA pin width
`define FB_COL_W            9
`define FB_BURST_LEN        8     // Words per burst
`define FB_FIFO_DEPTH       32
`define FB_FRAME_WORDS      256   // One stored frame

// ========================================
// SDRAM timing, in CLK cycles
// ========================================
`define FB_CAS_LAT          2
`define FB_T_RCD            2     // ACTIVE to READ or WRITE
`define FB_T_RP             2
`define FB_T_RFC            7
`define FB_REFRESH_INTERVAL 390
`define FB_INIT_WAIT        20    // Idle NOPs after power-up

// Burst length 8, sequential, CAS latency 2
`define FB_MODE_WORD        13'h023

`endif

/* src/sdram_pkg.sv */
`include "fb_defs.svh"

package sdram_pkg;

	// Pin command, coded as {RAS_N, CAS_N, WE_N} with CS_N low
	typedef enum logic [2:0] {
		LOAD_MODE = 3'b000,
		REFRESH   = 3'b001,
		PRECHARGE = 3'b010,
		ACTIVE    = 3'b011,
		WRITE     = 3'b100,
		READ      = 3'b101,
		NOP       = 3'b111
	} sdram_cmd_t;

	// Address fields
	typedef logic [`FB_ROW_W-1:0]  sdram_row_t;
	typedef logic [`FB_COL_W-1:0]  sdram_col_t;
	typedef logic [`FB_BANK_W-1:0] sdram_bank_t;
	typedef logic [`FB_ROW_W-1:0]  sdram_addr_t; // SA pins, row or column phase

endpackage

/* src/fb_pkg.sv */
`include "fb_defs.svh"

package fb_pkg;

	typedef logic [`FB_DATA_W-1:0] pixel_t;

	// Word address, {bank, row, col}
	typedef logic [`FB_BANK_W+`FB_ROW_W+`FB_COL_W-1:0] frame_addr_t;

	// Fill count, 0 up to full
	typedef logic [$clog2(`FB_FIFO_DEPTH+1)-1:0] fifo_level_t;

	// Arbiter phases
	typedef enum logic [1:0] {
		IDLE,          // Fill phase, waiting for a full burst
		WAIT_DONE,     // One burst in flight
		SCANOUT_READY  // Frame stored, waiting for read FIFO room
	} arb_state_t;

endpackage

/* src/burst_if.sv */
`timescale 1ns/1ps

// Burst request link, arbiter to sequencer
interface burst_if;

	logic                start; // One-cycle request, only while busy low
	logic                write; // 1 for write burst
	fb_pkg::frame_addr_t addr;  // First word of the burst
	logic                busy;  // Rises the cycle after start
	logic                done;  // Last beat moved, busy falls here

	modport requester (
		output start, write, addr,
		input  busy, done
	);

	modport executor (
		input  start, write, addr,
		output busy, done
	);

endinterface

/* src/stream_fifo.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

// Synchronous FIFO, first-word fall-through
module stream_fifo (
	input  logic                CLK,
	input  logic                RESET_N,
	input  logic                push,
	input  fb_pkg::pixel_t      push_data,
	input  logic                pop,
	output fb_pkg::pixel_t      pop_data,
	output fb_pkg::fifo_level_t level
);
	localparam int PTR_W = $clog2(`FB_FIFO_DEPTH);

	fb_pkg::pixel_t   mem [`FB_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	assign pop_data = mem[rd_ptr]; // Head word, valid while level nonzero

	always_ff @(posedge CLK)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1; // Power-of-two depth wraps itself
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level; // Both or neither
			endcase
		end
	end

endmodule

/* src/burst_arbiter.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

module burst_arbiter (
	input  logic                CLK,
	input  logic                RESET_N,
	input  fb_pkg::fifo_level_t wr_level,
	input  fb_pkg::fifo_level_t rd_level,
	burst_if.requester          bus
);
	// Start of the last burst in the frame
	localparam fb_pkg::frame_addr_t LAST_BURST =
		fb_pkg::frame_addr_t'(`FB_FRAME_WORDS - `FB_BURST_LEN);
	localparam fb_pkg::frame_addr_t BURST_STEP = fb_pkg::frame_addr_t'(`FB_BURST_LEN);

	fb_pkg::arb_state_t  state;
	fb_pkg::frame_addr_t fill_addr;   // Next write burst
	fb_pkg::frame_addr_t scan_addr;   // Next read burst
	fb_pkg::fifo_level_t rd_inflight; // Read words reserved, not yet counted in rd_level
	logic                want_wr;
	logic                want_rd;
	logic                cur_write;
	int                  rd_free;

	assign rd_free = `FB_FIFO_DEPTH - int'(rd_level) - int'(rd_inflight);

	// Conditions registered, start itself follows busy directly
	assign bus.start = !bus.busy &&
		((state == fb_pkg::IDLE && want_wr) || (state == fb_pkg::SCANOUT_READY && want_rd));
	assign bus.write = (state == fb_pkg::IDLE); // Fill phase only writes
	assign bus.addr  = (state == fb_pkg::IDLE) ? fill_addr : scan_addr;

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state       <= fb_pkg::IDLE;
			fill_addr   <= '0;
			scan_addr   <= '0;
			rd_inflight <= '0;
			want_wr     <= 1'b0;
			want_rd     <= 1'b0;
			cur_write   <= 1'b0;
		end
		else
		begin
			want_wr <= (wr_level >= `FB_BURST_LEN);
			want_rd <= (rd_free >= `FB_BURST_LEN); // Room for a whole burst
			if (bus.start)
			begin
				state     <= fb_pkg::WAIT_DONE;
				cur_write <= bus.write;
				if (!bus.write)
					rd_inflight <= fb_pkg::fifo_level_t'(`FB_BURST_LEN);
			end
			else if (state == fb_pkg::WAIT_DONE && bus.done)
			begin
				rd_inflight <= '0; // All beats pushed by now
				if (cur_write)
				begin
					fill_addr <= fill_addr + BURST_STEP;
					state     <= (fill_addr == LAST_BURST) ? fb_pkg::SCANOUT_READY : fb_pkg::IDLE;
				end
				else
				begin
					scan_addr <= (scan_addr == LAST_BURST) ? '0 : scan_addr + BURST_STEP;
					state     <= fb_pkg::SCANOUT_READY;
				end
			end
		end
	end

endmodule

/* src/sdram_sequencer.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

module sdram_sequencer (
	input  logic                   CLK,
	input  logic                   RESET_N,
	burst_if.executor              bus,
	output logic                   wr_pop,  // One per write beat
	input  fb_pkg::pixel_t         wr_data,
	output logic                   rd_push, // One per sampled read beat
	output fb_pkg::pixel_t         rd_data,
	output fb_pkg::pixel_t         dq_out,
	output logic                   dq_oe,
	input  fb_pkg::pixel_t         dq_in,
	output sdram_pkg::sdram_addr_t sa,
	output sdram_pkg::sdram_bank_t ba,
	output logic                   cs_n,
	output logic                   cke,
	output logic                   ras_n,
	output logic                   cas_n,
	output logic                   we_n
);
	localparam int REF_W = $clog2(`FB_REFRESH_INTERVAL + 1);
	localparam sdram_pkg::sdram_addr_t AP_BIT = sdram_pkg::sdram_addr_t'(1 << 10); // A10

	typedef enum logic [3:0] {
		S_INIT, S_INIT_PRE, S_INIT_REF1, S_INIT_REF2, S_INIT_MRS,
		S_IDLE, S_REFRESH, S_RCD, S_DATA, S_TAIL
	} seq_state_t;

	seq_state_t             state;
	logic [7:0]             cnt;     // Countdown within a state
	logic [REF_W-1:0]       ref_cnt; // Cycles since last refresh
	logic                   ref_due;
	logic                   ref_go;
	sdram_pkg::sdram_cmd_t  cmd;
	sdram_pkg::sdram_bank_t req_bank;
	sdram_pkg::sdram_row_t  req_row;
	sdram_pkg::sdram_col_t  req_col;
	sdram_pkg::sdram_bank_t cur_bank;
	sdram_pkg::sdram_col_t  cur_col;
	logic                   cur_write;
	logic                   rd_beat;
	logic [`FB_CAS_LAT:0]   rd_mark; // Read beats waiting out CAS latency
	logic                   done_q;
	fb_pkg::pixel_t         dq_q;

	// Split {bank, row, col}
	assign req_col  = bus.addr[`FB_COL_W-1:0];
	assign req_row  = bus.addr[`FB_COL_W +: `FB_ROW_W];
	assign req_bank = bus.addr[`FB_COL_W+`FB_ROW_W +: `FB_BANK_W];

	assign ref_due  = (ref_cnt == REF_W'(`FB_REFRESH_INTERVAL - 1));
	assign ref_go   = (state == S_IDLE) && !bus.start && ref_due;
	assign bus.busy = (state != S_IDLE) || ref_due; // Due refresh blocks new bursts
	assign bus.done = done_q;
	assign {ras_n, cas_n, we_n} = cmd;

	// Pop one cycle ahead so the word is on DQ with its beat
	assign wr_pop  = cur_write && ((state == S_RCD && cnt == '0) || (state == S_DATA && cnt != '0));
	assign rd_beat = !cur_write && (state == S_DATA);
	assign rd_push = rd_mark[`FB_CAS_LAT];
	assign rd_data = dq_q;

	// ========================================
	// Command FSM
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state     <= S_INIT;
			cnt       <= 8'(`FB_INIT_WAIT - 1);
			cmd       <= sdram_pkg::NOP;
			sa        <= '0;
			ba        <= '0;
			cs_n      <= 1'b0;
			cke       <= 1'b1;
			cur_write <= 1'b0;
			done_q    <= 1'b0;
		end
		else
		begin
			cmd    <= sdram_pkg::NOP; // Default every cycle
			cs_n   <= 1'b0;
			cke    <= 1'b1;
			done_q <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			case (state)
				S_INIT: if (cnt == '0)
				begin
					cmd   <= sdram_pkg::PRECHARGE; // All banks
					sa    <= AP_BIT;
					cnt   <= 8'(`FB_T_RP - 1);
					state <= S_INIT_PRE;
				end
				S_INIT_PRE, S_INIT_REF1: if (cnt == '0)
				begin
					cmd   <= sdram_pkg::REFRESH;
					cnt   <= 8'(`FB_T_RFC - 1);
					state <= (state == S_INIT_PRE) ? S_INIT_REF1 : S_INIT_REF2;
				end
				S_INIT_REF2: if (cnt == '0)
				begin
					cmd   <= sdram_pkg::LOAD_MODE;
					sa    <= `FB_MODE_WORD;
					ba    <= '0;
					cnt   <= 8'd1; // Mode register set time
					state <= S_INIT_MRS;
				end
				S_INIT_MRS, S_REFRESH: if (cnt == '0)
					state <= S_IDLE;
				S_IDLE:
				begin
					if (bus.start)
					begin
						cmd       <= sdram_pkg::ACTIVE;
						ba        <= req_bank;
						sa        <= req_row;
						cur_write <= bus.write;
						cnt       <= 8'(`FB_T_RCD - 1);
						state     <= S_RCD;
					end
					else if (ref_go)
					begin
						cmd   <= sdram_pkg::REFRESH;
						cnt   <= 8'(`FB_T_RFC - 1);
						state <= S_REFRESH;
					end
				end
				S_RCD: if (cnt == '0)
				begin
					cmd   <= cur_write ? sdram_pkg::WRITE : sdram_pkg::READ;
					ba    <= cur_bank;
					sa    <= AP_BIT | sdram_pkg::sdram_addr_t'(cur_col); // Auto-precharge
					cnt   <= 8'(`FB_BURST_LEN - 1);
					state <= S_DATA;
				end
				S_DATA: if (cnt == '0)
				begin
					// Reads also wait out CAS latency and the sample register
					cnt   <= cur_write ? 8'(`FB_T_RP - 1) : 8'(`FB_CAS_LAT + `FB_T_RP);
					state <= S_TAIL;
				end
				S_TAIL: if (cnt == '0)
				begin
					done_q <= 1'b1;
					state  <= S_IDLE;
				end
				default: state <= S_INIT;
			endcase
		end
	end

	// Refresh interval, restarted by every refresh after init
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
			ref_cnt <= '0;
		else if (state == S_INIT_MRS || ref_go)
			ref_cnt <= '0;
		else if (!ref_due)
			ref_cnt <= ref_cnt + 1'b1;
	end

	// ========================================
	// Data path
	// ========================================
	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			dq_oe   <= 1'b0;
			rd_mark <= '0;
		end
		else
		begin
			dq_oe   <= wr_pop;
			rd_mark <= {rd_mark[`FB_CAS_LAT-1:0], rd_beat};
		end
	end

	always_ff @(posedge CLK)
	begin
		dq_out <= wr_data;
		dq_q   <= dq_in; // Sampled DQ, pushed with the delayed mark
		if (state == S_IDLE && bus.start)
		begin
			cur_bank <= req_bank;
			cur_col  <= req_col;
		end
	end

endmodule

/* src/scanout_credit.sv */
`timescale 1ns/1ps

// Pixel output, one pixel per granted credit
module scanout_credit (
	input  logic                CLK,
	input  logic                RESET_N,
	input  logic                pix_credit,
	input  fb_pkg::fifo_level_t rd_level,
	output logic                rd_pop,
	input  fb_pkg::pixel_t      pix_data_in,
	output logic                pix_valid,
	output fb_pkg::pixel_t      pix_data
);
	logic [15:0] credits; // Granted, not yet used

	assign rd_pop = (credits != '0) && (rd_level != '0);

	always_ff @(posedge CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			credits   <= '0;
			pix_valid <= 1'b0;
		end
		else
		begin
			credits   <= credits + 16'(pix_credit) - 16'(rd_pop); // Grant and use together
			pix_valid <= rd_pop;
		end
	end

	always_ff @(posedge CLK)
	begin
		if (rd_pop)
			pix_data <= pix_data_in;
	end

endmodule

/* src/fb_sdram_top.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

module fb_sdram_top (
	input  logic                      CLK,
	input  logic                      RESET_N,
	// Host write stream
	input  logic                      in_valid,
	input  fb_pkg::pixel_t            in_data,
	output logic                      in_credit,
	// Pixel output
	input  logic                      pix_credit,
	output logic                      pix_valid,
	output fb_pkg::pixel_t            pix_data,
	// SDRAM pins
	output sdram_pkg::sdram_addr_t    sa,
	output sdram_pkg::sdram_bank_t    ba,
	output logic                      cs_n,
	output logic                      cke,
	output logic                      ras_n,
	output logic                      cas_n,
	output logic                      we_n,
	output logic [`FB_DATA_W/8-1:0]   dqm,
	inout  wire fb_pkg::pixel_t       dq
);
	logic                wr_pop;
	logic                rd_push;
	logic                rd_pop;
	logic                dq_oe;
	fb_pkg::pixel_t      wr_data;  // Write FIFO head
	fb_pkg::pixel_t      rd_data;  // Sampled SDRAM word
	fb_pkg::pixel_t      rd_head;  // Read FIFO head
	fb_pkg::pixel_t      dq_out;
	fb_pkg::fifo_level_t wr_level;
	fb_pkg::fifo_level_t rd_level;

	burst_if bus0 ();

	// ========================================
	// Stream FIFOs
	// ========================================
	stream_fifo wr_fifo0 (.CLK, .RESET_N, .push(in_valid), .push_data(in_data),
		.pop(wr_pop), .pop_data(wr_data), .level(wr_level));

	stream_fifo rd_fifo0 (.CLK, .RESET_N, .push(rd_push), .push_data(rd_data),
		.pop(rd_pop), .pop_data(rd_head), .level(rd_level));

	// ========================================
	// Burst control and SDRAM side
	// ========================================
	burst_arbiter arb0 (.CLK, .RESET_N, .wr_level, .rd_level, .bus(bus0.requester));

	sdram_sequencer seq0 (.CLK, .RESET_N, .bus(bus0.executor), .wr_pop, .wr_data,
		.rd_push, .rd_data, .dq_out, .dq_oe, .dq_in(dq),
		.sa, .ba, .cs_n, .cke, .ras_n, .cas_n, .we_n);

	scanout_credit credit0 (.CLK, .RESET_N, .pix_credit, .rd_level, .rd_pop,
		.pix_data_in(rd_head), .pix_valid, .pix_data);

	assign in_credit = wr_pop;                  // Each word sent to SDRAM frees a slot
	assign dq        = dq_oe ? dq_out : 'z;     // Drive only during write beats
	assign dqm       = '0;                      // No byte masking

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

// 20 ns clock, reset low for the first 2 rising edges
module tb_clock_gen (
	output logic CLK,
	output logic RESET_N
);
	initial
	begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	initial
	begin
		RESET_N = 1'b0;
		repeat (2) @(posedge CLK);
		#2 RESET_N = 1'b1; // Released with the other inputs
	end

endmodule

/* tests/tb_checker.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

// Watches the DUT ports at the falling edge, where every output is settled
module tb_checker (
	input  logic        CLK,
	input  logic        RESET_N,
	input  logic        in_valid,
	input  logic [15:0] in_data,
	input  logic        in_credit,
	input  logic        pix_credit,
	input  logic        pix_valid,
	input  logic [15:0] pix_data,
	input  logic        cs_n,
	input  logic        cke,
	input  logic        ras_n,
	input  logic        cas_n,
	input  logic        we_n,
	input  logic [1:0]  dqm,
	input  logic        stall,
	output int          errors,
	output logic        done
);
	// Refresh interval plus one read burst from ACTIVE to done
	localparam int REF_LIMIT = `FB_REFRESH_INTERVAL + 2 + `FB_T_RCD + `FB_BURST_LEN
		+ `FB_CAS_LAT + `FB_T_RP + 2;
	localparam int TOTAL_PIX = 2 * `FB_FRAME_WORDS; // Two scanout passes

	logic [15:0] frame [`FB_FRAME_WORDS]; // Host pixels in order
	logic [2:0]  cmd;
	logic        reset_seen;
	logic        init_done;
	logic        stall_q;
	int          n_in;
	int          n_credit;
	int          n_pix;
	int          outstanding; // Credits granted, pixel not yet seen
	int          stall_allow;
	int          stall_pix;
	int          since_ref;
	int          n_ref;
	int          err_reset;
	int          err_frame;
	int          err_repeat;
	int          err_credit;
	int          err_refresh;

	assign cmd    = {ras_n, cas_n, we_n};
	assign errors = err_reset + err_frame + err_repeat + err_credit + err_refresh;

	function automatic string verdict(input int n);
		return (n == 0) ? "PASS" : "FAIL";
	endfunction

	initial
	begin
		done        = 1'b0;
		reset_seen  = 1'b0;
		init_done   = 1'b0;
		stall_q     = 1'b0;
		n_in        = 0;
		n_credit    = 0;
		n_pix       = 0;
		outstanding = 0;
		stall_allow = 0;
		stall_pix   = 0;
		since_ref   = 0;
		n_ref       = 0;
		err_reset   = 0;
		err_frame   = 0;
		err_repeat  = 0;
		err_credit  = 0;
		err_refresh = 0;
	end

	always @(negedge CLK)
	begin
		// ========================================
		// Outputs in and just after reset
		// ========================================
		if (!reset_seen)
		begin
			if (pix_valid !== 1'b0 || in_credit !== 1'b0)
			begin
				$display("Stream outputs not idle around reset");
				err_reset++;
			end
			if (cmd !== sdram_pkg::NOP || cke !== 1'b1 || cs_n !== 1'b0)
			begin
				$display("[FAIL] sdram cmd exp 7 cke 1 cs_n 0 got %h cke %h cs_n %h",
					cmd, cke, cs_n);
				err_reset++;
			end
			if (dqm !== 2'b00)
			begin
				$display("[FAIL] dqm exp 0 got %h", dqm);
				err_reset++;
			end
			if (RESET_N)
			begin
				reset_seen = 1'b1;
				$display("Test reset outputs: %s", verdict(err_reset));
			end
		end
		else if (!done)
		begin
			// Host words give the expected frame
			if (in_valid)
			begin
				if (n_in < `FB_FRAME_WORDS)
					frame[n_in] = in_data;
				n_in++;
			end
			if (in_credit)
				n_credit++;
			if (n_credit > n_in)
			begin
				$display("More in_credit pulses (%0d) than words sent (%0d)", n_credit, n_in);
				err_credit++;
			end

			// Byte masks stay off or written pixels get lost
			if (dqm !== 2'b00)
			begin
				$display("[FAIL] dqm exp 0 got %h", dqm);
				err_frame++;
			end

			// Pixels in the stretch only for credits already out
			if (stall && !stall_q)
			begin
				stall_allow = outstanding;
				stall_pix   = 0;
			end
			stall_q = stall;

			// ========================================
			// Pixel output
			// ========================================
			if (pix_valid)
			begin
				if (outstanding == 0)
				begin
					$display("pix_valid with no outstanding credit at pixel %0d", n_pix);
					err_credit++;
				end
				else
					outstanding--;
				if (stall)
				begin
					stall_pix++;
					if (stall_pix > stall_allow)
					begin
						$display("Pixel output during credit-free stretch");
						err_credit++;
					end
				end
				if (n_in < `FB_FRAME_WORDS)
				begin
					$display("Pixel %0d appeared before the frame was stored", n_pix);
					err_frame++;
				end
				else if (pix_data !== frame[n_pix % `FB_FRAME_WORDS])
				begin
					$display("[FAIL] pix_data #%0d exp %h got %h", n_pix,
						frame[n_pix % `FB_FRAME_WORDS], pix_data);
					if (n_pix < `FB_FRAME_WORDS)
						err_frame++;
					else
						err_repeat++;
				end
				n_pix++;
				if (n_pix == `FB_FRAME_WORDS)
					$display("Test frame readback: %s", verdict(err_frame));
			end
			if (pix_credit)
				outstanding++; // Usable from the next cycle

			// ========================================
			// Refresh spacing
			// ========================================
			if (!cs_n && cmd == sdram_pkg::LOAD_MODE)
			begin
				init_done = 1'b1;
				since_ref = 0;
			end
			else if (init_done)
			begin
				if (!cs_n && cmd == sdram_pkg::REFRESH)
				begin
					n_ref++;
					since_ref = 0;
				end
				else
				begin
					since_ref++;
					if (since_ref == REF_LIMIT + 1)
					begin
						$display("No REFRESH within %0d cycles", REF_LIMIT);
						err_refresh++;
					end
				end
			end

			if (n_pix == TOTAL_PIX)
			begin
				if (n_ref == 0)
				begin
					$display("No periodic REFRESH seen after init");
					err_refresh++;
				end
				$display("Test frame repeat: %s", verdict(err_repeat));
				$display("Test credit discipline: %s", verdict(err_credit));
				$display("Test refresh: %s (%0d refreshes)", verdict(err_refresh), n_ref);
				$display("Tests: 5, checks failed: %0d, pixels: %0d", errors, n_pix);
				done = 1'b1;
			end
		end
	end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps
`include "fb_defs.svh"

module tb_top;
	localparam int WATCHDOG_NS = 40 * (`FB_FRAME_WORDS * 3 + `FB_INIT_WAIT + 2000);
	localparam int STALL_CYCLES = 300;
	localparam int MAX_OUTSTANDING = 4; // Consumer credit window

	logic        CLK;
	logic        RESET_N;
	logic        in_valid;
	logic [15:0] in_data;
	logic        in_credit;
	logic        pix_credit;
	logic        pix_valid;
	logic [15:0] pix_data;
	logic [12:0] sa;
	logic [1:0]  ba;
	logic        cs_n;
	logic        cke;
	logic        ras_n;
	logic        cas_n;
	logic        we_n;
	logic [1:0]  dqm;
	wire  [15:0] dq;
	logic        model_oe;
	logic [15:0] model_dq;
	logic        stall;
	int          errors;
	logic        done;

	logic [31:0] lfsr;
	int          host_credits;
	int          host_sent;
	int          granted;
	int          seen;
	int          stall_left;
	logic        stalled_once;

	tb_clock_gen clk0 (.CLK, .RESET_N);

	fb_sdram_top dut0 (.CLK, .RESET_N, .in_valid, .in_data, .in_credit, .pix_credit,
		.pix_valid, .pix_data, .sa, .ba, .cs_n, .cke, .ras_n, .cas_n, .we_n, .dqm, .dq);

	tb_checker chk0 (.CLK, .RESET_N, .in_valid, .in_data, .in_credit, .pix_credit,
		.pix_valid, .pix_data, .cs_n, .cke, .ras_n, .cas_n, .we_n, .dqm, .stall, .errors,
		.done);

	assign dq = model_oe ? model_dq : 'z;

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// ========================================
	// SDRAM model
	// ========================================
	logic [15:0] mem [int];       // Key is {bank, row, col}
	logic [12:0] open_row [4];
	int          bl;
	int          cl;
	int          wr_left;
	int          rd_left;
	int          rd_wait;
	logic [1:0]  wr_ba;
	logic [1:0]  rd_ba;
	logic [8:0]  wr_col;
	logic [8:0]  rd_col;

	function automatic int word_key(input logic [1:0] b, input logic [12:0] r,
		input logic [8:0] c);
		return int'({b, r, c});
	endfunction

	always @(negedge CLK)
	begin
		// Read word held across the DUT's sampling edge
		if (rd_left > 0)
		begin
			if (rd_wait > 1)
				rd_wait--;
			else
			begin
				model_oe = 1'b1;
				model_dq = mem.exists(word_key(rd_ba, open_row[rd_ba], rd_col)) ?
					mem[word_key(rd_ba, open_row[rd_ba], rd_col)] : 16'hdead;
				rd_col++;
				rd_left--;
			end
		end
		else
			model_oe = 1'b0;
		if (wr_left > 0) // Remaining write beats
		begin
			mem[word_key(wr_ba, open_row[wr_ba], wr_col)] = dq;
			wr_col++;
			wr_left--;
		end
		if (!cs_n && cke)
		begin
			case ({ras_n, cas_n, we_n})
				sdram_pkg::ACTIVE: open_row[ba] = sa;
				sdram_pkg::WRITE:
				begin
					mem[word_key(ba, open_row[ba], sa[8:0])] = dq; // First beat with command
					wr_ba   = ba;
					wr_col  = sa[8:0] + 1'b1;
					wr_left = bl - 1;
				end
				sdram_pkg::READ:
				begin
					rd_ba   = ba;
					rd_col  = sa[8:0];
					rd_left = bl;
					rd_wait = cl;
				end
				sdram_pkg::LOAD_MODE:
				begin
					bl = 1 << sa[2:0];
					cl = int'(sa[6:4]);
				end
				default: ;
			endcase
		end
	end

	// ========================================
	// Host and consumer stimulus
	// ========================================
	always @(negedge CLK)
	begin
		if (in_credit)
			host_credits++; // Word left the write FIFO
		if (pix_valid)
			seen++;
	end

	initial
	begin
		logic [31:0] r;
		lfsr         = 32'h79ace1ec;
		in_valid     = 1'b0;
		in_data      = '0;
		pix_credit   = 1'b0;
		model_oe     = 1'b0;
		model_dq     = '0;
		stall        = 1'b0;
		bl           = 1;
		cl           = 2;
		wr_left      = 0;
		rd_left      = 0;
		rd_wait      = 0;
		host_credits = `FB_FIFO_DEPTH;
		host_sent    = 0;
		granted      = 0;
		seen         = 0;
		stall_left   = 0;
		stalled_once = 1'b0;
		@(posedge RESET_N);
		forever
		begin
			@(posedge CLK);
			#2;
			r = take_bits(2); // Send on 3 cycles of 4
			in_valid = (host_sent < `FB_FRAME_WORDS) && (host_credits > 0) && (r[1:0] != 0);
			r = take_bits(16);
			in_data = r[15:0];
			if (in_valid)
			begin
				host_credits--;
				host_sent++;
			end
			// Pause in the second pass lets the read FIFO fill
			if (!stalled_once && seen >= `FB_FRAME_WORDS + `FB_FRAME_WORDS / 4)
			begin
				stalled_once = 1'b1;
				stall        = 1'b1;
				stall_left   = STALL_CYCLES;
			end
			r = take_bits(1);
			if (stall)
			begin
				pix_credit = 1'b0;
				stall_left--;
				if (stall_left == 0)
					stall = 1'b0;
			end
			else
				pix_credit = r[0] && (granted - seen < MAX_OUTSTANDING);
			if (pix_credit)
				granted++;
		end
	end

	// ========================================
	// End of run
	// ========================================
	initial
	begin
		wait (done === 1'b1);
		@(posedge CLK);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, frame scanout did not complete", WATCHDOG_NS);
		$display("Errors found");
		$finish;
	end

endmodule

/* build.f */
+incdir+src
src/sdram_pkg.sv
src/fb_pkg.sv
src/burst_if.sv
src/stream_fifo.sv
src/burst_arbiter.sv
src/sdram_sequencer.sv
src/scanout_credit.sv
src/fb_sdram_top.sv
tests/tb_clock_gen.sv
tests/tb_checker.sv
tests/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the frame buffer testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f build.f --top-module tb_top -o sim_fb
./obj_dir/sim_fb | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
